// ==== common/line_pkg.sv ====
`default_nettype none

package line_pkg;

  // Pixel and kernel geometry
  localparam int PIX_W = 8;
  localparam int ROWS = 3;
  localparam int MAX_ROW_WIDTH = 64;

  // Column address and row width counters
  localparam int ADDR_W = $clog2(MAX_ROW_WIDTH);
  localparam int WIDTH_W = ADDR_W + 1;

  // Write order over the rotating rows
  localparam int ORDER_W = $clog2(ROWS);

  // Kernel weights add up to 16
  localparam int NORM_SHIFT = 4;
  localparam int WSUM_W = PIX_W + NORM_SHIFT;

  typedef logic [PIX_W-1:0] pixel_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WIDTH_W-1:0] width_t;

  // Oldest row sits in the lowest slot
  typedef logic [ROWS*PIX_W-1:0] column_t;

  typedef logic [WSUM_W-1:0] wsum_t;

endpackage

`default_nettype wire

// ==== common/row_read_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface row_read_if import line_pkg::*; ();

  logic    rd_en;
  addr_t   rd_addr;
  column_t rd_column;
  logic    rows_full;
  // Frees the oldest row after a full scan
  logic    row_release;

  modport initiator (
    output rd_en,
    output rd_addr,
    output row_release,
    input  rd_column,
    input  rows_full
  );

  modport target (
    input  rd_en,
    input  rd_addr,
    input  row_release,
    output rd_column,
    output rows_full
  );

endinterface

`default_nettype wire

// ==== common/column_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface column_if import line_pkg::*; ();

  logic    col_valid;
  logic    col_ready;
  column_t col_pixels;
  // High on column 0 of a row
  logic    col_first;

  modport source (
    output col_valid,
    output col_pixels,
    output col_first,
    input  col_ready
  );

  modport sink (
    input  col_valid,
    input  col_pixels,
    input  col_first,
    output col_ready
  );

endinterface

`default_nettype wire

// ==== line_buffer/row_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_ram import line_pkg::*; (
  input  logic   clk,
  input  logic   wr_en,
  input  addr_t  wr_addr,
  input  pixel_t wr_data,
  input  logic   rd_en,
  input  addr_t  rd_addr,
  output pixel_t rd_data
);

  // One image row held in block RAM
  pixel_t mem [MAX_ROW_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== line_buffer/line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_buffer import line_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  width_t     row_width,
  input  logic       wr_en,
  input  pixel_t     wr_data,
  output logic       wr_stall,
  row_read_if.target rd
);

  // Row that takes the next write, also the oldest stored row
  logic [ORDER_W-1:0] wr_order;
  addr_t              wr_addr;
  logic [ROWS-1:0]    row_full;
  logic               wr_go;
  logic               row_end;
  pixel_t             ram_data [ROWS];
  column_t            rot_column;

  assign wr_stall = row_full[wr_order];
  assign wr_go = wr_en && !wr_stall;
  assign row_end = (width_t'(wr_addr) == row_width - width_t'(1));
  assign rd.rows_full = &row_full;

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    row_ram row_ram_i (
      .clk     (clk),
      .wr_en   (wr_go && (wr_order == ORDER_W'(i))),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd.rd_en),
      .rd_addr (rd.rd_addr),
      .rd_data (ram_data[i])
    );
  end

  // Rotate so the oldest row lands in slot 0
  always_comb begin
    for (int i = 0; i < ROWS; i++) begin
      rot_column[i*PIX_W +: PIX_W] = ram_data[(i + int'(wr_order)) % ROWS];
    end
  end

  assign rd.rd_column = rot_column;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
      wr_order <= '0;
      row_full <= '0;
    end else begin
      if (wr_go) begin
        if (row_end) begin
          // Move on to the next memory at the end of a row
          wr_addr <= '0;
          row_full[wr_order] <= 1'b1;
          if (wr_order == ORDER_W'(ROWS - 1)) begin
            wr_order <= '0;
          end else begin
            wr_order <= wr_order + 1'b1;
          end
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
      // Writes stall during a scan and wr_order still points at the oldest row
      if (rd.row_release) begin
        row_full[wr_order] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pixel_intake.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_intake import line_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   pix_req,
  input  pixel_t pix_data,
  output logic   pix_ack,
  input  logic   wr_stall,
  output logic   wr_en,
  output pixel_t wr_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_acked,
    st_wait_release
  } state_t;

  state_t state;
  logic   accept;

  // Pixel goes in once the target row is free
  assign accept = pix_req && !wr_stall &&
                  ((state == st_idle) || (state == st_wait_release));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      pix_ack <= 1'b0;
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept;
      case (state)
        st_idle: begin
          if (pix_req) begin
            if (wr_stall) begin
              state <= st_wait_release;
            end else begin
              state <= st_acked;
              pix_ack <= 1'b1;
            end
          end
        end
        // Wait for the scanner to free a row
        st_wait_release: begin
          if (!wr_stall) begin
            state <= st_acked;
            pix_ack <= 1'b1;
          end
        end
        st_acked: begin
          if (!pix_req) begin
            state <= st_idle;
            pix_ack <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_data <= pix_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/row_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_scanner import line_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  width_t        row_width,
  row_read_if.initiator rd,
  column_if.source      col
);

  typedef enum logic [1:0] {
    st_idle,
    st_scan,
    st_release
  } state_t;

  state_t state;
  // Reads issued so far in this scan
  width_t col_cnt;
  logic   rd_pend;
  logic   slot_last;
  logic   col_take;

  assign col_take = col.col_valid && col.col_ready;

  // Read only into an empty slot with nothing in flight
  assign rd.rd_en = (state == st_scan) && !col.col_valid && !rd_pend &&
                    (col_cnt < row_width);
  assign rd.rd_addr = col_cnt[ADDR_W-1:0];
  assign rd.row_release = (state == st_release);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      col_cnt <= '0;
      rd_pend <= 1'b0;
      col.col_valid <= 1'b0;
    end else begin
      rd_pend <= rd.rd_en;
      if (rd.rd_en) begin
        col_cnt <= col_cnt + 1'b1;
      end
      if (rd_pend) begin
        col.col_valid <= 1'b1;
      end else if (col_take) begin
        col.col_valid <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (rd.rows_full) begin
            state <= st_scan;
            col_cnt <= '0;
          end
        end
        st_scan: begin
          if (col_take && slot_last) begin
            state <= st_release;
          end
        end
        st_release: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // col_cnt is already one ahead of the column being loaded
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      col.col_pixels <= rd.rd_column;
      col.col_first <= (col_cnt == width_t'(1));
      slot_last <= (col_cnt == row_width);
    end
  end

endmodule

`default_nettype wire

// ==== source/window_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_filter import line_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  column_if.sink  col,
  output logic    res_req,
  output pixel_t  res_data,
  input  logic    res_ack
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_finish
  } state_t;

  state_t  state;
  // win[0] is the leftmost column of the window
  column_t win [ROWS];
  logic [1:0] col_idx;
  logic [1:0] next_idx;
  logic    col_take;
  wsum_t   sum;

  // Vertical 1-2-1 weighting of one column
  function automatic wsum_t col_weight(column_t c);
    wsum_t acc;
    acc = wsum_t'(c[0 +: PIX_W]) +
          (wsum_t'(c[PIX_W +: PIX_W]) << 1) +
          wsum_t'(c[2*PIX_W +: PIX_W]);
    return acc;
  endfunction

  assign col.col_ready = (state == st_idle);
  assign col_take = col.col_valid && col.col_ready;

  // Column index in the row saturates at 2
  assign next_idx = col.col_first ? 2'd0 :
                    (col_idx == 2'd2) ? 2'd2 : col_idx + 2'd1;

  // Horizontal 1-2-1 over the window
  assign sum = col_weight(win[0]) + (col_weight(win[1]) << 1) + col_weight(win[2]);
  assign res_data = pixel_t'(sum >> NORM_SHIFT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      res_req <= 1'b0;
      col_idx <= '0;
    end else begin
      if (col_take) begin
        col_idx <= next_idx;
      end
      case (state)
        st_idle: begin
          if (col_take && (next_idx == 2'd2)) begin
            state <= st_send;
            res_req <= 1'b1;
          end
        end
        st_send: begin
          if (res_ack) begin
            state <= st_finish;
            res_req <= 1'b0;
          end
        end
        // Wait for the sink to drop ack before the next column
        st_finish: begin
          if (!res_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (col_take) begin
      win[0] <= win[1];
      win[1] <= win[2];
      win[2] <= col.col_pixels;
    end
  end

endmodule

`default_nettype wire

// ==== source/blur_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_top import line_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  width_t row_width,
  input  logic   pix_req,
  input  pixel_t pix_data,
  output logic   pix_ack,
  output logic   res_req,
  output pixel_t res_data,
  input  logic   res_ack
);

  logic   wr_en;
  pixel_t wr_data;
  logic   wr_stall;

  row_read_if rd_bus ();
  column_if   col_bus ();

  pixel_intake pixel_intake_i (
    .clk      (clk),
    .rst      (rst),
    .pix_req  (pix_req),
    .pix_data (pix_data),
    .pix_ack  (pix_ack),
    .wr_stall (wr_stall),
    .wr_en    (wr_en),
    .wr_data  (wr_data)
  );

  line_buffer line_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .row_width (row_width),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .wr_stall  (wr_stall),
    .rd        (rd_bus.target)
  );

  row_scanner row_scanner_i (
    .clk       (clk),
    .rst       (rst),
    .row_width (row_width),
    .rd        (rd_bus.initiator),
    .col       (col_bus.source)
  );

  window_filter window_filter_i (
    .clk      (clk),
    .rst      (rst),
    .col      (col_bus.sink),
    .res_req  (res_req),
    .res_data (res_data),
    .res_ack  (res_ack)
  );

endmodule

`default_nettype wire

// ==== test/blur_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_tb import line_pkg::*;;

  localparam int TIMEOUT = 5000;
  localparam int KIND_RAMP = 0;
  localparam int KIND_FLAT = 1;
  localparam int KIND_RANDOM = 2;

  logic   clk;
  logic   rst;
  width_t row_width;
  logic   pix_req;
  pixel_t pix_data;
  logic   pix_ack;
  logic   res_req;
  pixel_t res_data;
  logic   res_ack;

  // Stimulus image in row-major order and the expected outputs
  pixel_t img [$];
  pixel_t exp_q [$];

  int check_count;
  int error_count;
  int timeout_count;
  int result_count;
  int pix_wait_max;
  bit abort;

  blur_top blur_top_i (
    .clk       (clk),
    .rst       (rst),
    .row_width (row_width),
    .pix_req   (pix_req),
    .pix_data  (pix_data),
    .pix_ack   (pix_ack),
    .res_req   (res_req),
    .res_data  (res_data),
    .res_ack   (res_ack)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Next drive point is 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic apply_reset(input int w);
    rst = 1'b1;
    row_width = width_t'(w);
    pix_req = 1'b0;
    res_ack = 1'b0;
    repeat (2) step();
    rst = 1'b0;
  endtask

  // 1-2-1 by 1-2-1 kernel around (r, c) divided by 16
  function automatic pixel_t blur_at(input int r, input int c, input int w);
    int sum;
    int wr;
    int wc;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        wr = (dr == 0) ? 2 : 1;
        wc = (dc == 0) ? 2 : 1;
        sum += wr * wc * int'(img[(r + dr) * w + c + dc]);
      end
    end
    return pixel_t'(sum / 16);
  endfunction

  task automatic build_image(input int w, input int rows, input int kind);
    pixel_t p;
    img.delete();
    exp_q.delete();
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < w; c++) begin
        case (kind)
          KIND_RAMP: p = pixel_t'((r * 24 + c * 9) & 255);
          KIND_FLAT: p = 8'hA5;
          default:   p = pixel_t'($urandom);
        endcase
        img.push_back(p);
      end
    end
    // Interior pixels only
    for (int r = 1; r < rows - 1; r++) begin
      for (int c = 1; c < w - 1; c++) begin
        exp_q.push_back(blur_at(r, c, w));
      end
    end
  endtask

  task automatic send_pixel(input pixel_t data);
    int n;
    if (abort) begin
      return;
    end
    pix_data = data;
    pix_req = 1'b1;
    n = 0;
    while (!pix_ack && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!pix_ack) begin
      $display("ERROR: pix_ack did not rise within %0d cycles", TIMEOUT);
      timeout_count++;
      abort = 1'b1;
      pix_req = 1'b0;
      return;
    end
    if (n > pix_wait_max) begin
      pix_wait_max = n;
    end
    pix_req = 1'b0;
    n = 0;
    while (pix_ack && n < TIMEOUT) begin
      step();
      n++;
    end
    if (pix_ack) begin
      $display("ERROR: pix_ack did not fall within %0d cycles", TIMEOUT);
      timeout_count++;
      abort = 1'b1;
    end
  endtask

  task automatic get_result(input pixel_t expected, input bit use_delay);
    int n;
    int d;
    if (abort) begin
      return;
    end
    n = 0;
    while (!res_req && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!res_req) begin
      $display("ERROR: no result request within %0d cycles", TIMEOUT);
      timeout_count++;
      abort = 1'b1;
      return;
    end
    check_value("res_data", 32'(res_data), 32'(expected));
    result_count++;
    if (use_delay) begin
      d = int'($urandom % 6);
      repeat (d) step();
    end
    res_ack = 1'b1;
    n = 0;
    while (res_req && n < TIMEOUT) begin
      step();
      n++;
    end
    res_ack = 1'b0;
    if (res_req) begin
      $display("ERROR: res_req did not fall within %0d cycles", TIMEOUT);
      timeout_count++;
      abort = 1'b1;
    end
  endtask

  // No result may show up for the given number of cycles
  task automatic expect_quiet(input int cycles);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < cycles) begin
      step();
      seen = res_req;
      n++;
    end
    check_value("res_req", 32'(seen), 32'(0));
  endtask

  task automatic test_two_rows();
    $display("Test idle: two rows of width 8");
    apply_reset(8);
    check_value("pix_ack", 32'(pix_ack), 32'(0));
    check_value("res_req", 32'(res_req), 32'(0));
    build_image(8, 2, KIND_RAMP);
    for (int i = 0; i < 16; i++) begin
      send_pixel(img[i]);
    end
    expect_quiet(200);
  endtask

  task automatic run_image(input string name, input int w, input int rows,
                           input int kind, input bit use_delay);
    int n_exp;
    $display("Test %s: width %0d, %0d rows", name, w, rows);
    build_image(w, rows, kind);
    n_exp = exp_q.size();
    result_count = 0;
    apply_reset(w);
    fork
      begin
        for (int i = 0; i < w * rows; i++) begin
          send_pixel(img[i]);
        end
      end
      begin
        for (int i = 0; i < n_exp; i++) begin
          get_result(exp_q[i], use_delay);
        end
      end
    join
    // The last two rows stay stored and give no output
    expect_quiet(50);
    check_value("result_count", 32'(result_count), 32'(n_exp));
  endtask

  initial begin
    void'($urandom(48));
    rst = 1'b1;
    row_width = width_t'(8);
    pix_req = 1'b0;
    pix_data = '0;
    res_ack = 1'b0;
    check_count = 0;
    error_count = 0;
    timeout_count = 0;
    result_count = 0;
    pix_wait_max = 0;
    abort = 1'b0;

    test_two_rows();
    run_image("ramp", 8, 6, KIND_RAMP, 1'b0);
    run_image("flat", 8, 5, KIND_FLAT, 1'b0);

    // Random images with a slow result sink make the intake stall
    pix_wait_max = 0;
    run_image("random", 8, 7, KIND_RANDOM, 1'b1);
    check_value("pix_ack_stall", 32'(pix_wait_max > 3), 32'(1));
    run_image("random", 13, 5, KIND_RANDOM, 1'b1);

    run_image("narrow", 3, 5, KIND_RANDOM, 1'b0);
    run_image("wide", 64, 4, KIND_RANDOM, 1'b1);

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
common/line_pkg.sv
common/row_read_if.sv
common/column_if.sv
line_buffer/row_ram.sv
line_buffer/line_buffer.sv
source/pixel_intake.sv
source/row_scanner.sv
source/window_filter.sv
source/blur_top.sv
test/blur_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the blur testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module blur_tb -f files.f --Mdir obj_dir -o blur_sim \
  && ./obj_dir/blur_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qF "*** PASSED ***" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
